// ==== Makefile ====
# Verilator simulation of the data memory subsystem.

TOP := mem_subsystem_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --timescale 1ns/1ps -f mem_subsystem.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG)
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
	input  logic              clk,
	input  logic              reset,
	input  logic              data_req,
	input  logic              fetch_req,
	output logic              data_ack,
	output logic              fetch_ack,
	input  mem_pkg::bus_cmd_t data_cmd,
	input  mem_pkg::bus_cmd_t fetch_cmd,
	output mem_pkg::bus_rsp_t data_rsp,
	output mem_pkg::bus_rsp_t fetch_rsp,
	output mem_pkg::bus_cmd_t mem_cmd,
	input  mem_pkg::bus_rsp_t mem_rsp
);
	import mem_pkg::*;

	arb_state_t state_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= arb_idle;
		end else begin
			case (state_q)
				arb_idle: begin
					if (data_req)
						state_q <= arb_data;    // Data side wins a tie.
					else if (fetch_req)
						state_q <= arb_fetch;
				end
				arb_data: begin
					if (!data_req)
						state_q <= arb_idle;
				end
				arb_fetch: begin
					if (!fetch_req)
						state_q <= arb_idle;
				end
				default: begin
					state_q <= arb_idle;
				end
			endcase
		end
	end

	assign data_ack = (state_q == arb_data);
	assign fetch_ack = (state_q == arb_fetch);

	always_comb begin
		case (state_q)
			arb_data:  mem_cmd = data_cmd;
			arb_fetch: mem_cmd = fetch_cmd;
			default:   mem_cmd = '0;    // Idle bus, memory counter clears.
		endcase
	end

	// Read data is shared; only the owner sees ready.
	always_comb begin
		data_rsp.rdata = mem_rsp.rdata;
		data_rsp.ready = mem_rsp.ready && data_ack;
		fetch_rsp.rdata = mem_rsp.rdata;
		fetch_rsp.ready = mem_rsp.ready && fetch_ack;
	end

endmodule

// ==== logic/dcache.sv ====
`timescale 1ns/1ps

module dcache (
	input  logic              clk,
	input  logic              reset,
	input  logic [31:0]       addr,
	input  logic              rd_req,
	input  logic              wr_req,
	input  logic [31:0]       wr_data,
	output logic [31:0]       rd_data,
	output logic              rw_wait,
	output logic              bus_req,
	input  logic              bus_ack,
	output mem_pkg::bus_cmd_t bus_cmd,
	input  mem_pkg::bus_rsp_t bus_rsp
);
	import mem_pkg::*;

	localparam int word_w = offset_w - 2;    // Word select within a line.
	localparam int line_w = 32 - offset_w;   // Line-aligned address bits.
	localparam int num_lines = 2 ** index_w;

	logic valid_q [num_lines];
	logic [tag_w-1:0] tag_q [num_lines];
	logic [31:0] data_q [num_lines * line_words];    // Indexed by {line, word}.

	logic [tag_w-1:0]   tag;
	logic [index_w-1:0] idx;
	logic [word_w-1:0]  word;
	logic [line_w-1:0]  line;

	fill_state_t       state_q;
	logic [word_w-1:0] fill_cnt_q;     // Next word of the line to fetch.
	logic [line_w-1:0] fill_line_q;    // Line being filled.

	logic hit;
	logic read_miss;
	logic line_changed;
	logic fill_ready;
	logic fill_last;
	logic write_done;

	assign tag = addr[31 -: tag_w];
	assign idx = addr[offset_w +: index_w];
	assign word = addr[offset_w-1:2];
	assign line = addr[31:offset_w];

	assign hit = valid_q[idx] && (tag_q[idx] == tag);
	assign read_miss = rd_req && !hit && !wr_req;

	// The core moved to another line while a fill was under way.
	assign line_changed = (state_q == fill) && (line != fill_line_q);

	assign fill_ready = (state_q == fill) && read_miss && !line_changed &&
		bus_ack && bus_rsp.ready;
	assign fill_last = fill_ready && (fill_cnt_q == word_w'(line_words - 1));
	assign write_done = wr_req && bus_ack && bus_rsp.ready;

	// Hits answer in the request cycle.
	assign rd_data = data_q[{idx, word}];
	assign rw_wait = read_miss || (wr_req && !write_done);
	assign bus_req = read_miss || wr_req;

	always_comb begin
		bus_cmd = '0;
		if (wr_req) begin
			bus_cmd.addr = {addr[31:2], 2'b00};    // Write-through, one word.
			bus_cmd.wdata = wr_data;
			bus_cmd.wr = 1'b1;
		end else if (read_miss && !line_changed) begin
			bus_cmd.addr = {line, fill_cnt_q, 2'b00};
			bus_cmd.rd = 1'b1;
		end
		// A dropped rd for one cycle makes memory restart its wait count
		// so no stale word lands in a restarted fill.
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= idle;
			fill_cnt_q <= '0;
			fill_line_q <= '0;
			for (int i = 0; i < num_lines; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			case (state_q)
				idle: begin
					if (read_miss) begin
						state_q <= fill;
						fill_cnt_q <= '0;
						fill_line_q <= line;
					end
				end
				fill: begin
					if (!read_miss) begin
						state_q <= idle;    // Request withdrawn.
						fill_cnt_q <= '0;
					end else if (line_changed) begin
						fill_cnt_q <= '0;    // Start over on the new line.
						fill_line_q <= line;
					end else if (fill_ready) begin
						fill_cnt_q <= fill_cnt_q + 1'b1;
						if (fill_cnt_q == '0)
							valid_q[idx] <= 1'b0;    // Old contents going away.
						if (fill_last) begin
							valid_q[idx] <= 1'b1;
							state_q <= done;
						end
					end
				end
				done: begin
					state_q <= idle;    // Bus request already low here.
				end
				default: begin
					state_q <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fill_ready)
			data_q[{idx, fill_cnt_q}] <= bus_rsp.rdata;
		else if (write_done && hit)
			data_q[{idx, word}] <= wr_data;    // Keep the cached copy current.
		if (fill_last)
			tag_q[idx] <= tag;
	end

endmodule

// ==== logic/main_memory.sv ====
`timescale 1ns/1ps

module main_memory #(
	parameter int mem_wait_cycles = 2,
	parameter int mem_addr_w = 12
) (
	input  logic              clk,
	input  logic              reset,
	input  mem_pkg::bus_cmd_t cmd,
	output mem_pkg::bus_rsp_t rsp
);

	localparam int cnt_w = (mem_wait_cycles > 0) ? $clog2(mem_wait_cycles + 1) : 1;
	localparam int depth = 2 ** mem_addr_w;

	logic [31:0] mem_q [depth];
	logic [cnt_w-1:0] cnt_q;
	logic [mem_addr_w-1:0] word_addr;
	logic active;
	logic at_count;
	logic ready_q;
	logic [31:0] rdata_q;

	assign word_addr = cmd.addr[mem_addr_w+1:2];    // Drop the byte offset.
	assign active = cmd.rd || cmd.wr;
	assign at_count = active && (cnt_q == cnt_w'(mem_wait_cycles));

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt_q <= '0;
			ready_q <= 1'b0;
		end else if (!active) begin
			cnt_q <= '0;
			ready_q <= 1'b0;
		end else if (at_count) begin
			cnt_q <= '0;    // Next access counts afresh.
			ready_q <= 1'b1;
		end else begin
			cnt_q <= cnt_q + 1'b1;
			ready_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (at_count) begin
			if (cmd.wr)
				mem_q[word_addr] <= cmd.wdata;
			rdata_q <= mem_q[word_addr];
		end
	end

	assign rsp.rdata = rdata_q;
	assign rsp.ready = ready_q;

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

	// Address split: [31:10] tag, [9:6] line index, [5:0] byte offset.
	localparam int tag_w = 22;
	localparam int index_w = 4;
	localparam int offset_w = 6;
	localparam int line_words = 16;    // 64-byte line of 32-bit words.

	// One requester's command, or the granted command on the memory side.
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        rd;
		logic        wr;
	} bus_cmd_t;

	// Memory answer; ready pulses once per completed word.
	typedef struct packed {
		logic [31:0] rdata;
		logic        ready;
	} bus_rsp_t;

	// Data cache line fill sequencing.
	typedef enum logic [1:0] {
		idle,
		fill,
		done
	} fill_state_t;

	// Memory bus owner.
	typedef enum logic [1:0] {
		arb_idle,
		arb_data,
		arb_fetch
	} arb_state_t;

endpackage

// ==== logic/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem #(
	parameter int mem_wait_cycles = 2,
	parameter int mem_addr_w = 12
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] addr,
	input  logic        rd_req,
	input  logic        wr_req,
	input  logic [31:0] wr_data,
	output logic [31:0] rd_data,
	output logic        rw_wait,
	input  logic [31:0] fetch_addr,
	input  logic        fetch_req,
	output logic [31:0] fetch_data,
	output logic        fetch_wait
);
	import mem_pkg::*;

	logic     data_req;
	logic     data_ack;
	bus_cmd_t data_cmd;
	bus_cmd_t fetch_cmd;
	bus_cmd_t mem_cmd;
	bus_rsp_t data_rsp;
	bus_rsp_t fetch_rsp;
	bus_rsp_t mem_rsp;

	dcache dcache0 (
		.clk     (clk),
		.reset   (reset),
		.addr    (addr),
		.rd_req  (rd_req),
		.wr_req  (wr_req),
		.wr_data (wr_data),
		.rd_data (rd_data),
		.rw_wait (rw_wait),
		.bus_req (data_req),
		.bus_ack (data_ack),
		.bus_cmd (data_cmd),
		.bus_rsp (data_rsp)
	);

	// Fetch port, uncached single-word reads.
	always_comb begin
		fetch_cmd = '0;
		fetch_cmd.addr = {fetch_addr[31:2], 2'b00};
		fetch_cmd.rd = fetch_req;
	end

	assign fetch_data = fetch_rsp.rdata;
	assign fetch_wait = fetch_req && !fetch_rsp.ready;

	bus_arbiter arb0 (
		.clk       (clk),
		.reset     (reset),
		.data_req  (data_req),
		.fetch_req (fetch_req),
		.data_ack  (data_ack),
		.fetch_ack (),
		.data_cmd  (data_cmd),
		.fetch_cmd (fetch_cmd),
		.data_rsp  (data_rsp),
		.fetch_rsp (fetch_rsp),
		.mem_cmd   (mem_cmd),
		.mem_rsp   (mem_rsp)
	);

	main_memory #(
		.mem_wait_cycles (mem_wait_cycles),
		.mem_addr_w      (mem_addr_w)
	) mem0 (
		.clk   (clk),
		.reset (reset),
		.cmd   (mem_cmd),
		.rsp   (mem_rsp)
	);

endmodule

// ==== mem_subsystem.f ====
+incdir+tests
logic/mem_pkg.sv
logic/bus_arbiter.sv
logic/dcache.sv
logic/main_memory.sv
logic/mem_subsystem.sv
tests/mem_subsystem_tb.sv

// ==== tests/mem_subsystem_tb_table.svh ====
// Columns: test name, operation, byte address, data hit expected in the request cycle.
// Lines 0x100 and 0x500 share index 4; 0x300 uses index 12, 0xC40 index 1.

task automatic load_table();
	// Fill a line by writes, then miss once and hit inside it.
	add_row("fill_wr_0100", op_write, 32'h0000_0100, 1'b0);
	add_row("fill_wr_0104", op_write, 32'h0000_0104, 1'b0);
	add_row("fill_wr_0108", op_write, 32'h0000_0108, 1'b0);
	add_row("fill_wr_013c", op_write, 32'h0000_013C, 1'b0);
	add_row("fill_rd_miss", op_read, 32'h0000_0104, 1'b0);
	add_row("fill_rd_hit_last", op_read, 32'h0000_013C, 1'b1);
	add_row("fill_rd_hit_first", op_read, 32'h0000_0100, 1'b1);

	// Write hit updates the line and reaches memory.
	add_row("update_wr", op_write, 32'h0000_0108, 1'b0);
	add_row("update_rd_hit", op_read, 32'h0000_0108, 1'b1);
	add_row("update_fetch", op_fetch, 32'h0000_0108, 1'b0);

	// Write miss leaves the line unallocated.
	add_row("noalloc_wr", op_write, 32'h0000_0300, 1'b0);
	add_row("noalloc_rd_miss", op_read, 32'h0000_0300, 1'b0);
	add_row("noalloc_rd_hit", op_read, 32'h0000_0300, 1'b1);

	// Same index, other tag.
	add_row("evict_wr", op_write, 32'h0000_0500, 1'b0);
	add_row("evict_rd_new", op_read, 32'h0000_0500, 1'b0);
	add_row("evict_rd_old", op_read, 32'h0000_0104, 1'b0);
	add_row("evict_rd_new_again", op_read, 32'h0000_0500, 1'b0);

	// Data miss and fetch in the same cycle.
	add_row("both_wr", op_write, 32'h0000_0C40, 1'b0);
	add_row("both_rd_miss", op_read_fetch, 32'h0000_0C40, 1'b0);
	add_row("both_rd_hit", op_read_fetch, 32'h0000_0C40, 1'b1);

	// Reset clears valid bits but not memory.
	add_row("reset_rd_hit", op_read, 32'h0000_0500, 1'b1);
	add_row("reset_mid", op_reset, 32'h0000_0000, 1'b0);
	add_row("reset_rd_miss", op_read, 32'h0000_0500, 1'b0);
	add_row("reset_rd_hit_again", op_read, 32'h0000_0500, 1'b1);
endtask

// ==== tests/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb;
	import mem_pkg::*;

	localparam int timeout_cycles = 2000;
	localparam int num_lines = 2 ** index_w;

	typedef enum int {
		op_write,
		op_read,
		op_fetch,
		op_read_fetch,
		op_reset
	} op_kind_t;

	logic        clk;
	logic        reset;
	logic [31:0] addr;
	logic        rd_req;
	logic        wr_req;
	logic [31:0] wr_data;
	logic [31:0] rd_data;
	logic        rw_wait;
	logic [31:0] fetch_addr;
	logic        fetch_req;
	logic [31:0] fetch_data;
	logic        fetch_wait;

	string       row_name [$];
	op_kind_t    row_op [$];
	logic [31:0] row_addr [$];
	logic        row_hit [$];

	logic [31:0]      ref_mem [logic [31:0]];    // Written words, by aligned address.
	logic             ref_valid [num_lines];
	logic [tag_w-1:0] ref_tag [num_lines];

	int checks;
	int mismatches;
	int timeouts;

	mem_subsystem dut0 (
		.clk        (clk),
		.reset      (reset),
		.addr       (addr),
		.rd_req     (rd_req),
		.wr_req     (wr_req),
		.wr_data    (wr_data),
		.rd_data    (rd_data),
		.rw_wait    (rw_wait),
		.fetch_addr (fetch_addr),
		.fetch_req  (fetch_req),
		.fetch_data (fetch_data),
		.fetch_wait (fetch_wait)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic add_row(input string name, input op_kind_t op, input logic [31:0] a,
		input logic hit);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(a);
		row_hit.push_back(hit);
	endtask

	`include "mem_subsystem_tb_table.svh"

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] model_word(input logic [31:0] a);
		if (ref_mem.exists({a[31:2], 2'b00}))
			return ref_mem[{a[31:2], 2'b00}];
		return '0;
	endfunction

	// Direct mapped: one tag per index.
	function automatic logic model_hit(input logic [31:0] a);
		return ref_valid[a[offset_w +: index_w]] &&
			(ref_tag[a[offset_w +: index_w]] == a[31 -: tag_w]);
	endfunction

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		rd_req = 1'b0;
		wr_req = 1'b0;
		fetch_req = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < num_lines; i++)
			ref_valid[i] = 1'b0;    // Reset drops every line.
		#1;
		check_bit("reset rw_wait", 1'b0, rw_wait);
		check_bit("reset fetch_wait", 1'b0, fetch_wait);
	endtask

	task automatic run_write(input string name, input logic [31:0] a);
		int cycles;
		logic [31:0] value;
		cycles = 0;
		value = $urandom;
		@(negedge clk);
		addr = a;
		wr_data = value;
		wr_req = 1'b1;
		do begin
			@(negedge clk);
			cycles++;
		end while (rw_wait && cycles < timeout_cycles);
		if (rw_wait) begin
			timeouts++;
			$display("%s: data port never finished the write in %0d cycles", name,
				timeout_cycles);
		end
		@(negedge clk);    // Request held through the edge that ends the ready cycle.
		wr_req = 1'b0;
		ref_mem[{a[31:2], 2'b00}] = value;    // Write-through, no allocate.
	endtask

	task automatic run_reads(input string name, input logic [31:0] a, input logic exp_hit,
		input logic use_data, input logic use_fetch);
		int cycles;
		logic data_finished;
		logic fetch_finished;
		logic [31:0] expected;
		cycles = 0;
		data_finished = !use_data;
		fetch_finished = !use_fetch;
		expected = model_word(a);
		@(negedge clk);
		addr = a;
		rd_req = use_data;
		fetch_addr = a;
		fetch_req = use_fetch;
		#1;
		if (use_data) begin
			check_bit({name, " hit"}, exp_hit, !rw_wait);
			check_bit({name, " model hit"}, exp_hit, model_hit(a));    // Table sanity.
			ref_valid[a[offset_w +: index_w]] = 1'b1;    // Read miss allocates.
			ref_tag[a[offset_w +: index_w]] = a[31 -: tag_w];
		end
		while (!(data_finished && fetch_finished) && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
			if (!data_finished && !rw_wait) begin
				check_word({name, " data"}, expected, rd_data);
				data_finished = 1'b1;
				rd_req = 1'b0;
			end
			if (!fetch_finished && !fetch_wait) begin
				check_word({name, " fetch"}, expected, fetch_data);
				fetch_finished = 1'b1;
				fetch_req = 1'b0;
			end
		end
		if (!data_finished) begin
			timeouts++;
			$display("%s: data port never finished the read in %0d cycles", name,
				timeout_cycles);
		end
		if (!fetch_finished) begin
			timeouts++;
			$display("%s: fetch port never finished the read in %0d cycles", name,
				timeout_cycles);
		end
		rd_req = 1'b0;
		fetch_req = 1'b0;
	endtask

	initial begin
		int seed_value;
		reset = 1'b1;
		addr = '0;
		rd_req = 1'b0;
		wr_req = 1'b0;
		wr_data = '0;
		fetch_addr = '0;
		fetch_req = 1'b0;
		checks = 0;
		mismatches = 0;
		timeouts = 0;
		seed_value = $urandom(42192);
		load_table();
		apply_reset();
		foreach (row_op[i]) begin
			case (row_op[i])
				op_write:      run_write(row_name[i], row_addr[i]);
				op_read:       run_reads(row_name[i], row_addr[i], row_hit[i], 1'b1, 1'b0);
				op_fetch:      run_reads(row_name[i], row_addr[i], row_hit[i], 1'b0, 1'b1);
				op_read_fetch: run_reads(row_name[i], row_addr[i], row_hit[i], 1'b1, 1'b1);
				default:       apply_reset();
			endcase
		end
		@(negedge clk);
		$display("checks %0d, errors %0d (mismatches %0d, timeouts %0d)", checks,
			mismatches + timeouts, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
